// ==== src.f ====
verilog/apu_cfg_pkg.sv
verilog/apu_op_pkg.sv
verilog/apu_disp.sv
verilog/apu_arith.sv
verilog/apu_regfile.sv
verilog/apu_subsystem.sv
verification/apu_disp_sva.sv
verification/tb_clk_gen.sv
verification/tb_apu_subsystem.sv

// ==== verification/apu_disp_sva.sv ====
module apu_disp_sva (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           apu_req_i,
  input logic                           apu_gnt_i,
  input logic                           apu_rvalid_i,
  input logic                           stall_i,
  input logic                           valid_infl_i,
  input logic                           valid_wait_i,
  input logic [apu_cfg_pkg::REG_AW-1:0] addr_wait_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Every response has an owner among the pending operations
  a_rvalid_owned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    apu_rvalid_i |-> (valid_infl_i || valid_wait_i || (apu_req_i && apu_gnt_i)))
  else begin
    $error("response valid with no pending operation");
    fail_cnt++;
  end

  // An occupied waiting slot keeps its address
  a_wait_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_wait_i |=> (!valid_wait_i || $stable(addr_wait_i)))
  else begin
    $error("waiting slot address changed while occupied");
    fail_cnt++;
  end

  // The unit grants nothing the dispatcher holds back
  a_no_stall_acc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    apu_gnt_i |-> !stall_i)
  else begin
    $error("stall raised in the cycle of an accepted request");
    fail_cnt++;
  end

endmodule

bind apu_disp apu_disp_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .apu_req_i    (apu_req_o),
  .apu_gnt_i    (apu_gnt_i),
  .apu_rvalid_i (apu_rvalid_i),
  .stall_i      (stall_o),
  .valid_infl_i (valid_infl_q),
  .valid_wait_i (valid_wait_q),
  .addr_wait_i  (addr_wait_q)
);

// ==== verification/tb_apu_subsystem.sv ====
module tb_apu_subsystem;

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  localparam int PERIOD    = 4;
  localparam int N_OPS     = 300;
  localparam int STALL_CYC = 2;
  localparam int TIMEOUT   = (8 + N_OPS * (DIV_STEPS + 4) * STALL_CYC) * PERIOD;

  // One accepted operation as the model sees it
  typedef struct packed {
    logic [REG_AW-1:0] dst;
    apu_lat_e          lat;
    logic [DATA_W-1:0] res;
    logic              timed;
    logic [31:0]       acc;
  } pend_t;

  logic              clk;
  logic              rst_n;
  logic              issue_valid;
  apu_req_t          issue_req;
  logic              query_valid;
  dep_query_t        query;
  logic              stall;
  logic              active;
  logic              read_dep;
  logic              write_dep;
  logic              wb_valid;
  logic [REG_AW-1:0] wb_addr;
  logic [DATA_W-1:0] wb_data;

  pend_t             pend_q[$];
  logic [DATA_W-1:0] model_regs [NUM_REGS];
  integer            seed = 32'h9804_01e8;
  int                n_err = 0;
  int                n_chk = 0;
  int                n_acc = 0;
  logic [31:0]       cycle = '0;
  logic              took = 1'b0;
  logic              mon_on = 1'b0;
  logic              drv_on = 1'b0;

  tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(8)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  apu_subsystem uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .issue_valid_i (issue_valid),
    .issue_req_i   (issue_req),
    .query_valid_i (query_valid),
    .query_i       (query),
    .stall_o       (stall),
    .active_o      (active),
    .read_dep_o    (read_dep),
    .write_dep_o   (write_dep),
    .wb_valid_o    (wb_valid),
    .wb_addr_o     (wb_addr),
    .wb_data_o     (wb_data)
  );

  ////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_val(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    n_chk++;
    if (act !== exp) begin
      n_err++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, act, exp);
    end
  endtask

  function automatic logic [DATA_W-1:0] model_result(apu_opc_e opc,
                                                     logic [DATA_W-1:0] a,
                                                     logic [DATA_W-1:0] b);
    logic [2*DATA_W-1:0] prod;
    prod = a * b;
    case (opc)
      OPC_ADD: return a + b;
      OPC_XOR: return a ^ b;
      OPC_MUL: return prod[DATA_W-1:0];
      // Unsigned quotient with all ones for a zero divisor
      default: return (b == '0) ? '1 : a / b;
    endcase
  endfunction

  // Cycles from acceptance to writeback on an idle unit
  function automatic int lat_delay(apu_lat_e lat);
    case (lat)
      LAT_COMB: return 0;
      LAT_ONE:  return 1;
      LAT_TWO:  return 2;
      default:  return DIV_STEPS + 1;
    endcase
  endfunction

  function automatic logic query_hit(logic [REG_AW-1:0] dst, logic wr_side);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (!wr_side && query.rd_valid[i] && (query.rd_addr[i] == dst)) hit = 1'b1;
    end
    for (int i = 0; i < 2; i++) begin
      if (wr_side && query.wr_valid[i] && (query.wr_addr[i] == dst)) hit = 1'b1;
    end
    return hit;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_new_op();
    logic [31:0] r;
    apu_req_t    req;
    r = $random(seed);
    // Each opcode sits in its own latency class
    req.opc   = apu_opc_e'(r[1:0]);
    req.lat   = apu_lat_e'(r[1:0]);
    // Narrow address range so dependencies show up
    req.dst   = REG_AW'(r[4:2]);
    req.src_a = REG_AW'(r[7:5]);
    req.src_b = REG_AW'(r[10:8]);
    issue_req   <= req;
    issue_valid <= (r[31:30] != 2'b00);
  endtask

  task automatic drive_query();
    logic [31:0] r;
    dep_query_t  q;
    r = $random(seed);
    q.rd_addr[0] = REG_AW'(r[2:0]);
    q.rd_addr[1] = REG_AW'(r[5:3]);
    q.rd_addr[2] = REG_AW'(r[8:6]);
    q.rd_valid   = r[11:9];
    q.wr_addr[0] = REG_AW'(r[14:12]);
    q.wr_addr[1] = REG_AW'(r[17:15]);
    q.wr_valid   = r[19:18];
    query       <= q;
    query_valid <= r[20] | r[21];
  endtask

  always @(posedge clk) begin
    if (drv_on) begin
      // A refused request is held until taken
      if (!issue_valid || took) begin
        if (n_acc < N_OPS) begin
          drive_new_op();
        end else begin
          issue_valid <= 1'b0;
        end
      end
      drive_query();
    end
  end

  ////////////////////////////////////////////////////////////
  // Sampling and checks on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic sample_cycle();
    pend_t e;
    logic  forbid;
    logic  ret_head;
    logic  req_pend;
    logic  rd_exp;
    logic  wr_exp;
    cycle++;
    // Fullness and type rules against the slots in use
    forbid = (pend_q.size() >= 2);
    if (pend_q.size() == 1) begin
      forbid = (issue_req.lat == LAT_ONE) || (issue_req.lat == LAT_ITER) ||
               ((issue_req.lat == LAT_TWO) && (pend_q[$].lat == LAT_ITER));
    end
    if (issue_valid && forbid) compare_val("stall_o", stall, 1'b1);
    // Busy while any accepted operation has not returned
    compare_val("active_o", active, pend_q.size() != 0);
    // Oldest pending operation leaves this cycle or the request itself when nothing is older
    ret_head = wb_valid && (pend_q.size() != 0);
    req_pend = issue_valid && !forbid && !(wb_valid && (pend_q.size() == 0));
    rd_exp   = req_pend && query_hit(issue_req.dst, 1'b0);
    wr_exp   = req_pend && query_hit(issue_req.dst, 1'b1);
    for (int i = ret_head ? 1 : 0; i < pend_q.size(); i++) begin
      rd_exp |= query_hit(pend_q[i].dst, 1'b0);
      wr_exp |= query_hit(pend_q[i].dst, 1'b1);
    end
    compare_val("read_dep_o", read_dep, query_valid && rd_exp);
    compare_val("write_dep_o", write_dep, query_valid && wr_exp);
    // Operands come from the registers before this cycle's writeback
    took = issue_valid && !stall;
    if (took) begin
      e.dst   = issue_req.dst;
      e.lat   = issue_req.lat;
      e.res   = model_result(issue_req.opc, model_regs[issue_req.src_a],
                             model_regs[issue_req.src_b]);
      e.timed = (pend_q.size() == 0);
      e.acc   = cycle;
      pend_q.push_back(e);
      n_acc++;
    end
    if (wb_valid) begin
      if (pend_q.size() == 0) begin
        n_err++;
        $display("Writeback at %0t while no operation was pending", $time);
      end else begin
        e = pend_q.pop_front();
        compare_val("wb_addr_o", wb_addr, e.dst);
        compare_val("wb_data_o", wb_data, e.res);
        if (e.timed) compare_val("wb_valid_o delay", cycle - e.acc, lat_delay(e.lat));
        model_regs[e.dst] = e.res;
      end
    end
  endtask

  always @(negedge clk) begin
    if (mon_on) begin
      sample_cycle();
    end
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Timeout after %0d time units, operations never finished", TIMEOUT);
    $display("Verification failed");
    $finish;
  end

  initial begin
    issue_valid = 1'b0;
    issue_req   = '0;
    // Query every address so empty slots must keep the dependency outputs low
    query_valid = 1'b1;
    query       = '1;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    // Quiet outputs straight after reset
    compare_val("stall_o", stall, 1'b0);
    compare_val("active_o", active, 1'b0);
    compare_val("wb_valid_o", wb_valid, 1'b0);
    compare_val("read_dep_o", read_dep, 1'b0);
    compare_val("write_dep_o", write_dep, 1'b0);
    mon_on <= 1'b1;
    drv_on <= 1'b1;
    // Run until every operation is taken and returned
    while ((n_acc < N_OPS) || (pend_q.size() != 0)) @(posedge clk);
    repeat (4) @(posedge clk);
    n_err = n_err + uut.u_disp.u_sva.fail_cnt;
    $display("Operations: %0d, checks: %0d, errors: %0d", n_acc, n_chk, n_err);
    if (n_err == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    // Release away from the rising edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== verilog/apu_arith.sv ====
module apu_arith (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  input  apu_op_pkg::apu_req_t           req_i,
  input  logic [apu_cfg_pkg::DATA_W-1:0] op_a_i,
  input  logic [apu_cfg_pkg::DATA_W-1:0] op_b_i,
  output logic                           gnt_o,
  output apu_op_pkg::apu_rsp_t           rsp_o
);

  import apu_cfg_pkg::*;

  logic                         accept;
  logic                         pipe_idle;
  logic                         pipe_busy;
  logic                         div_busy;
  logic                         add_now;
  logic                         s1_load;
  // XOR stage
  logic                         xor_vld_q;
  logic [DATA_W-1:0]            xor_res_q;
  // Two-stage pipe, MUL and delayed ADD
  logic                         s1_vld_q;
  logic                         s1_mul_q;
  logic [DATA_W-1:0]            s1_a_q;
  logic [DATA_W-1:0]            s1_b_q;
  logic                         s2_vld_q;
  logic [DATA_W-1:0]            s2_res_q;
  logic [2*DATA_W-1:0]          mul_full;
  // Restoring divider
  logic                         div_run_q;
  logic                         div_done_q;
  logic [$clog2(DIV_STEPS)-1:0] div_cnt_q;
  logic [DATA_W-1:0]            div_quo_q;
  logic [DATA_W-1:0]            div_rem_q;
  logic [DATA_W-1:0]            div_dsr_q;
  logic [DATA_W:0]              div_shift;
  logic [DATA_W:0]              div_diff;
  logic                         div_ge;

  assign pipe_busy = s1_vld_q | s2_vld_q;
  assign div_busy  = div_run_q | div_done_q;
  assign pipe_idle = ~xor_vld_q & ~pipe_busy & ~div_busy;

  // Divider blocks everything, a division also waits for the pipe
  assign gnt_o  = req_valid_i & ~div_busy & ~((req_i.opc == OPC_DIV) & pipe_busy);
  assign accept = req_valid_i & gnt_o;

  // ADD behind an older result takes the pipe to keep order
  assign add_now = accept & (req_i.opc == OPC_ADD) & pipe_idle;
  assign s1_load = accept & ((req_i.opc == OPC_MUL) ||
                             ((req_i.opc == OPC_ADD) && !pipe_idle));

  assign mul_full = s1_a_q * s1_b_q;

  // One restoring step
  assign div_shift = {div_rem_q, div_quo_q[DATA_W-1]};
  assign div_ge    = div_shift >= {1'b0, div_dsr_q};
  assign div_diff  = div_shift - {1'b0, div_dsr_q};

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xor_vld_q  <= 1'b0;
      s1_vld_q   <= 1'b0;
      s2_vld_q   <= 1'b0;
      div_run_q  <= 1'b0;
      div_done_q <= 1'b0;
      div_cnt_q  <= '0;
    end else begin
      xor_vld_q  <= accept & (req_i.opc == OPC_XOR);
      s1_vld_q   <= s1_load;
      s2_vld_q   <= s1_vld_q;
      // Done flag lasts one cycle
      div_done_q <= 1'b0;
      if (accept && (req_i.opc == OPC_DIV)) begin
        div_run_q <= 1'b1;
        div_cnt_q <= '0;
      end else if (div_run_q) begin
        div_cnt_q <= div_cnt_q + 1'b1;
        // Last step, result shows up next cycle
        if (div_cnt_q == ($clog2(DIV_STEPS))'(DIV_STEPS - 1)) begin
          div_run_q  <= 1'b0;
          div_done_q <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept && (req_i.opc == OPC_XOR)) begin
      xor_res_q <= op_a_i ^ op_b_i;
    end
    if (s1_load) begin
      s1_mul_q <= (req_i.opc == OPC_MUL);
      s1_a_q   <= op_a_i;
      s1_b_q   <= op_b_i;
    end
    // Low half of the product
    s2_res_q <= s1_mul_q ? mul_full[DATA_W-1:0] : s1_a_q + s1_b_q;
    if (accept && (req_i.opc == OPC_DIV)) begin
      div_quo_q <= op_a_i;
      div_rem_q <= '0;
      div_dsr_q <= op_b_i;
    end else if (div_run_q) begin
      // Zero divisor always subtracts, quotient ends all ones
      div_quo_q <= {div_quo_q[DATA_W-2:0], div_ge};
      div_rem_q <= div_ge ? div_diff[DATA_W-1:0] : div_shift[DATA_W-1:0];
    end
  end

  // Oldest finishing path wins
  always_comb begin
    rsp_o.valid = div_done_q | s2_vld_q | xor_vld_q | add_now;
    if (div_done_q) begin
      rsp_o.data = div_quo_q;
    end else if (s2_vld_q) begin
      rsp_o.data = s2_res_q;
    end else if (xor_vld_q) begin
      rsp_o.data = xor_res_q;
    end else begin
      rsp_o.data = op_a_i + op_b_i;
    end
  end

endmodule

// ==== verilog/apu_cfg_pkg.sv ====
package apu_cfg_pkg;

  // Register file geometry
  localparam int REG_AW   = 6;
  localparam int NUM_REGS = 64;

  // Operand and result width
  localparam int DATA_W = 16;

  // Iterations of the restoring divider
  localparam int DIV_STEPS = 16;

  // Latency class of an operation
  typedef enum logic [1:0] {
    LAT_COMB = 2'd0,
    LAT_ONE  = 2'd1,
    LAT_TWO  = 2'd2,
    LAT_ITER = 2'd3
  } apu_lat_e;

  // Opcodes, one per latency class
  typedef enum logic [1:0] {
    OPC_ADD = 2'd0,
    OPC_XOR = 2'd1,
    OPC_MUL = 2'd2,
    OPC_DIV = 2'd3
  } apu_opc_e;

endpackage

// ==== verilog/apu_disp.sv ====
module apu_disp (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Issue side
  input  logic                           enable_i,
  input  apu_op_pkg::apu_req_t           req_i,
  // Dependency query
  input  logic                           query_valid_i,
  input  apu_op_pkg::dep_query_t         query_i,
  // Unit handshake
  input  logic                           apu_gnt_i,
  input  logic                           apu_rvalid_i,
  output logic                           apu_req_o,
  // Writeback address in the response cycle
  output logic [apu_cfg_pkg::REG_AW-1:0] wb_addr_o,
  // Status
  output logic                           stall_o,
  output logic                           stall_type_o,
  output logic                           stall_nack_o,
  output logic                           active_o,
  output logic                           read_dep_o,
  output logic                           write_dep_o
);

  import apu_cfg_pkg::*;

  logic [REG_AW-1:0] addr_req;
  logic [REG_AW-1:0] addr_infl_q;
  logic [REG_AW-1:0] addr_infl_d;
  logic [REG_AW-1:0] addr_wait_q;
  logic [REG_AW-1:0] addr_wait_d;
  logic              valid_req;
  logic              valid_infl_q;
  logic              valid_infl_d;
  logic              valid_wait_q;
  logic              valid_wait_d;
  logic              ret_req;
  logic              ret_infl;
  logic              ret_wait;
  logic              req_acc;
  logic              active;
  apu_lat_e          lat_q;
  logic              stall_full;
  logic              stall_type;
  logic              stall_nack;
  logic [2:0]        rd_hit_req;
  logic [2:0]        rd_hit_infl;
  logic [2:0]        rd_hit_wait;
  logic [1:0]        wr_hit_req;
  logic [1:0]        wr_hit_infl;
  logic [1:0]        wr_hit_wait;
  logic              pend_req;
  logic              pend_infl;
  logic              pend_wait;

  ////////////////////////////////////////////////////////////
  // Request and return tracking
  ////////////////////////////////////////////////////////////

  // Request goes out unless stalled; a nack stall still requests
  assign valid_req = enable_i & ~(stall_full | stall_type);
  assign addr_req  = req_i.dst;
  assign req_acc   = valid_req & apu_gnt_i;

  // Unit is busy while any slot holds an operation
  assign active = valid_infl_q | valid_wait_q;

  // Response owner, the oldest pending operation
  assign ret_req  = req_acc & apu_rvalid_i & ~active;
  assign ret_infl = valid_infl_q & apu_rvalid_i & ~valid_wait_q;
  assign ret_wait = valid_wait_q & apu_rvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_infl_q <= 1'b0;
      valid_wait_q <= 1'b0;
      lat_q        <= LAT_COMB;
    end else begin
      valid_infl_q <= valid_infl_d;
      valid_wait_q <= valid_wait_d;
      // Class of the youngest accepted operation
      if (req_acc) begin
        lat_q <= req_i.lat;
      end
    end
  end

  // Slot addresses only count together with their valid bits
  always_ff @(posedge clk_i) begin
    addr_infl_q <= addr_infl_d;
    addr_wait_q <= addr_wait_d;
  end

  always_comb begin
    valid_infl_d = valid_infl_q;
    valid_wait_d = valid_wait_q;
    addr_infl_d  = addr_infl_q;
    addr_wait_d  = addr_wait_q;
    if (req_acc && !ret_req) begin
      // New operation enters the in-flight slot
      valid_infl_d = 1'b1;
      addr_infl_d  = addr_req;
      // Unreturned older one moves back to waiting
      if (valid_infl_q && !ret_infl) begin
        valid_wait_d = 1'b1;
        addr_wait_d  = addr_infl_q;
      end
    end else if (ret_infl) begin
      valid_infl_d = 1'b0;
    end else if (ret_wait) begin
      valid_wait_d = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////

  // Both slots taken
  assign stall_full = valid_infl_q & valid_wait_q;

  // A shorter latency behind a pending operation would overtake it
  assign stall_type = enable_i & active &
                      ((req_i.lat == LAT_ONE) || (req_i.lat == LAT_ITER) ||
                       ((req_i.lat == LAT_TWO) && (lat_q == LAT_ITER)));

  // Unit refused the request, retried next cycle
  assign stall_nack = valid_req & ~apu_gnt_i;

  assign stall_o      = stall_full | stall_type | stall_nack;
  assign stall_type_o = stall_type;
  assign stall_nack_o = stall_nack;
  assign apu_req_o    = valid_req;
  assign active_o     = active;

  ////////////////////////////////////////////////////////////
  // Dependency checks
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < 3; i++) begin : gen_rd_hit
    assign rd_hit_req[i]  = query_i.rd_valid[i] & (query_i.rd_addr[i] == addr_req);
    assign rd_hit_infl[i] = query_i.rd_valid[i] & (query_i.rd_addr[i] == addr_infl_q);
    assign rd_hit_wait[i] = query_i.rd_valid[i] & (query_i.rd_addr[i] == addr_wait_q);
  end

  for (genvar i = 0; i < 2; i++) begin : gen_wr_hit
    assign wr_hit_req[i]  = query_i.wr_valid[i] & (query_i.wr_addr[i] == addr_req);
    assign wr_hit_infl[i] = query_i.wr_valid[i] & (query_i.wr_addr[i] == addr_infl_q);
    assign wr_hit_wait[i] = query_i.wr_valid[i] & (query_i.wr_addr[i] == addr_wait_q);
  end

  // Pending and not writing back this cycle
  assign pend_req  = valid_req & ~ret_req;
  assign pend_infl = valid_infl_q & ~ret_infl;
  assign pend_wait = valid_wait_q & ~ret_wait;

  assign read_dep_o  = query_valid_i &
                       ((|rd_hit_req & pend_req) | (|rd_hit_infl & pend_infl) |
                        (|rd_hit_wait & pend_wait));
  assign write_dep_o = query_valid_i &
                       ((|wr_hit_req & pend_req) | (|wr_hit_infl & pend_infl) |
                        (|wr_hit_wait & pend_wait));

  // Writeback address follows the owner of the response
  always_comb begin
    if (ret_wait) begin
      wb_addr_o = addr_wait_q;
    end else if (ret_infl) begin
      wb_addr_o = addr_infl_q;
    end else if (ret_req) begin
      wb_addr_o = addr_req;
    end else begin
      wb_addr_o = '0;
    end
  end

endmodule

// ==== verilog/apu_op_pkg.sv ====
package apu_op_pkg;

  import apu_cfg_pkg::*;

  // Operation offered by the decode side
  typedef struct packed {
    apu_opc_e          opc;
    apu_lat_e          lat;
    logic [REG_AW-1:0] dst;
    logic [REG_AW-1:0] src_a;
    logic [REG_AW-1:0] src_b;
  } apu_req_t;

  // Result returned by the arithmetic unit
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              valid;
  } apu_rsp_t;

  // Register addresses of an instruction being decoded
  typedef struct packed {
    logic [2:0][REG_AW-1:0] rd_addr;
    logic [2:0]             rd_valid;
    logic [1:0][REG_AW-1:0] wr_addr;
    logic [1:0]             wr_valid;
  } dep_query_t;

endpackage

// ==== verilog/apu_regfile.sv ====
module apu_regfile (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Operand reads
  input  logic [apu_cfg_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [apu_cfg_pkg::REG_AW-1:0] raddr_b_i,
  output logic [apu_cfg_pkg::DATA_W-1:0] rdata_a_o,
  output logic [apu_cfg_pkg::DATA_W-1:0] rdata_b_o,
  // Result writeback
  input  logic                           we_i,
  input  logic [apu_cfg_pkg::REG_AW-1:0] waddr_i,
  input  logic [apu_cfg_pkg::DATA_W-1:0] wdata_i
);

  import apu_cfg_pkg::*;

  logic [DATA_W-1:0] regs_q [NUM_REGS];

  // All registers start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Plain combinational reads
  // a write lands only after the edge
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== verilog/apu_subsystem.sv ====
module apu_subsystem (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Issue side
  input  logic                           issue_valid_i,
  input  apu_op_pkg::apu_req_t           issue_req_i,
  // Dependency query
  input  logic                           query_valid_i,
  input  apu_op_pkg::dep_query_t         query_i,
  // Status
  output logic                           stall_o,
  output logic                           active_o,
  output logic                           read_dep_o,
  output logic                           write_dep_o,
  // Writeback
  output logic                           wb_valid_o,
  output logic [apu_cfg_pkg::REG_AW-1:0] wb_addr_o,
  output logic [apu_cfg_pkg::DATA_W-1:0] wb_data_o
);

  import apu_cfg_pkg::*;
  import apu_op_pkg::*;

  logic              apu_req;
  logic              apu_gnt;
  apu_rsp_t          apu_rsp;
  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;

  // Writeback seen from outside
  assign wb_valid_o = apu_rsp.valid;
  assign wb_data_o  = apu_rsp.data;

  apu_disp u_disp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (issue_valid_i),
    .req_i         (issue_req_i),
    .query_valid_i (query_valid_i),
    .query_i       (query_i),
    .apu_gnt_i     (apu_gnt),
    .apu_rvalid_i  (apu_rsp.valid),
    .apu_req_o     (apu_req),
    .wb_addr_o     (wb_addr_o),
    .stall_o       (stall_o),
    .stall_type_o  (),
    .stall_nack_o  (),
    .active_o      (active_o),
    .read_dep_o    (read_dep_o),
    .write_dep_o   (write_dep_o)
  );

  apu_arith u_arith (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (apu_req),
    .req_i       (issue_req_i),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .gnt_o       (apu_gnt),
    .rsp_o       (apu_rsp)
  );

  // Operands come from the sources of the current request
  apu_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_req_i.src_a),
    .raddr_b_i (issue_req_i.src_b),
    .rdata_a_o (op_a),
    .rdata_b_o (op_b),
    .we_i      (apu_rsp.valid),
    .waddr_i   (wb_addr_o),
    .wdata_i   (apu_rsp.data)
  );

endmodule
